//--- flist.f
hw/exec_pkg.sv
hw/fu_result_if.sv
hw/shift_control.sv
hw/shift_count.sv
hw/shift_datapath.sv
hw/logic_unit.sv
hw/cdb_arbiter.sv
hw/exec_cluster.sv
sim/exec_cluster_assertions.sv
sim/exec_cluster_tb.sv

//--- hw/cdb_arbiter.sv
/*
 * Common data bus arbiter.
 * One result per cycle, alternating priority when both units request.
 */

`timescale 1ns/100ps
`default_nettype none

module cdb_arbiter #(
  parameter int DATA_WIDTH = exec_pkg::DEFAULT_DATA_WIDTH,
  parameter int ROB_BITS = exec_pkg::DEFAULT_ROB_BITS
) (
  input  logic                  clk,
  input  logic                  reset,
  fu_result_if.arbiter          shift_res,
  fu_result_if.arbiter          logic_res,
  output logic                  cdb_valid,
  output logic [ROB_BITS-1:0]   cdb_rob_entry,
  output logic [DATA_WIDTH-1:0] cdb_result
);

  logic last_was_shift;
  logic grant_shift;
  logic grant_logic;
  logic contention;

  assign contention = shift_res.valid && logic_res.valid;

  // shift wins unless it also won the last contended cycle
  assign grant_shift = shift_res.valid && (!logic_res.valid || !last_was_shift);
  assign grant_logic = logic_res.valid && !grant_shift;

  assign shift_res.yumi = grant_shift;
  assign logic_res.yumi = grant_logic;

  always_ff @(posedge clk) begin
    if (reset) begin
      last_was_shift <= 1'b0;
    end else if (contention) begin
      last_was_shift <= grant_shift;
    end
  end

  // bus driven straight from the winner, no added latency
  assign cdb_valid = grant_shift || grant_logic;
  assign cdb_rob_entry = grant_shift ? shift_res.rob_entry : logic_res.rob_entry;
  assign cdb_result = grant_shift ? shift_res.result : logic_res.result;

endmodule

`default_nettype wire

//--- hw/exec_cluster.sv
/*
 * Execute cluster top level.
 * Iterative shift unit, single-cycle logic unit and the bus arbiter.
 */

`timescale 1ns/100ps
`default_nettype none

module exec_cluster #(
  parameter int DATA_WIDTH = exec_pkg::DEFAULT_DATA_WIDTH,
  parameter int ROB_BITS = exec_pkg::DEFAULT_ROB_BITS,
  localparam int AMT_BITS = $clog2(DATA_WIDTH)
) (
  input  logic                  clk,
  input  logic                  reset,
  input  logic                  shift_valid,
  input  exec_pkg::alu_op_t     shift_op,
  input  logic [DATA_WIDTH-1:0] shift_a,
  input  logic [DATA_WIDTH-1:0] shift_b,
  input  logic [ROB_BITS-1:0]   shift_rob,
  output logic                  shift_ready,
  input  logic                  alu_valid,
  input  exec_pkg::alu_op_t     alu_op,
  input  logic [DATA_WIDTH-1:0] alu_a,
  input  logic [DATA_WIDTH-1:0] alu_b,
  input  logic [ROB_BITS-1:0]   alu_rob,
  output logic                  alu_ready,
  output logic                  cdb_valid,
  output logic [ROB_BITS-1:0]   cdb_rob_entry,
  output logic [DATA_WIDTH-1:0] cdb_result
);

  logic                shift_load;
  logic                shift_shifting;
  logic                shift_done;
  logic                shift_step;
  logic                shift_count_last;
  logic [AMT_BITS-1:0] shift_amount;

  fu_result_if #(.DATA_WIDTH(DATA_WIDTH), .ROB_BITS(ROB_BITS)) shift_if ();
  fu_result_if #(.DATA_WIDTH(DATA_WIDTH), .ROB_BITS(ROB_BITS)) logic_if ();

  shift_control i_shift_control (
    .clk(clk), .reset(reset), .issue_valid(shift_valid),
    .count_last(shift_count_last), .yumi(shift_if.yumi),
    .load(shift_load), .shifting(shift_shifting), .done(shift_done),
    .ready(shift_ready)
  );

  shift_count #(.DATA_WIDTH(DATA_WIDTH)) i_shift_count (
    .clk(clk), .load(shift_load), .shifting(shift_shifting),
    .amount(shift_amount), .step(shift_step), .count_last(shift_count_last)
  );

  shift_datapath #(.DATA_WIDTH(DATA_WIDTH), .ROB_BITS(ROB_BITS)) i_shift_datapath (
    .clk(clk), .reset(reset), .load(shift_load), .step(shift_step),
    .done(shift_done), .op(shift_op), .a(shift_a), .b(shift_b),
    .rob(shift_rob), .amount(shift_amount), .res(shift_if.unit)
  );

  logic_unit #(.DATA_WIDTH(DATA_WIDTH), .ROB_BITS(ROB_BITS)) i_logic_unit (
    .clk(clk), .reset(reset), .issue_valid(alu_valid), .op(alu_op),
    .a(alu_a), .b(alu_b), .rob(alu_rob), .ready(alu_ready),
    .res(logic_if.unit)
  );

  cdb_arbiter #(.DATA_WIDTH(DATA_WIDTH), .ROB_BITS(ROB_BITS)) i_cdb_arbiter (
    .clk(clk), .reset(reset), .shift_res(shift_if.arbiter),
    .logic_res(logic_if.arbiter), .cdb_valid(cdb_valid),
    .cdb_rob_entry(cdb_rob_entry), .cdb_result(cdb_result)
  );

endmodule

`default_nettype wire

//--- hw/exec_pkg.sv
/*
 * Execute cluster shared definitions.
 * Operation codes for both functional units and default widths.
 */

`default_nettype none

package exec_pkg;

  // operand and reorder-buffer tag widths
  localparam int DEFAULT_DATA_WIDTH = 32;
  localparam int DEFAULT_ROB_BITS = 4;

  // operation codes, logic unit first, then shifts
  typedef enum logic [3:0] {
    OP_ADD = 4'd0,
    OP_SUB = 4'd1,
    OP_AND = 4'd2,
    OP_OR  = 4'd3,
    OP_XOR = 4'd4,
    OP_SLL = 4'd5,
    OP_SRL = 4'd6,
    OP_SRA = 4'd7
  } alu_op_t;

endpackage

`default_nettype wire

//--- hw/fu_result_if.sv
/*
 * Functional unit result path.
 * A unit holds valid, tag and value until the arbiter returns yumi.
 */

`timescale 1ns/100ps
`default_nettype none

interface fu_result_if #(
  parameter int DATA_WIDTH = exec_pkg::DEFAULT_DATA_WIDTH,
  parameter int ROB_BITS = exec_pkg::DEFAULT_ROB_BITS
);

  logic                  valid;
  logic [ROB_BITS-1:0]   rob_entry;
  logic [DATA_WIDTH-1:0] result;
  // one-cycle take pulse from the arbiter
  logic                  yumi;

  modport unit (output valid, output rob_entry, output result, input yumi);

  modport arbiter (input valid, input rob_entry, input result, output yumi);

endinterface

`default_nettype wire

//--- hw/logic_unit.sv
/*
 * Single-cycle logic unit.
 * Add, subtract and bitwise ops into a held result register.
 */

`timescale 1ns/100ps
`default_nettype none

module logic_unit #(
  parameter int DATA_WIDTH = exec_pkg::DEFAULT_DATA_WIDTH,
  parameter int ROB_BITS = exec_pkg::DEFAULT_ROB_BITS
) (
  input  logic                  clk,
  input  logic                  reset,
  input  logic                  issue_valid,
  input  exec_pkg::alu_op_t     op,
  input  logic [DATA_WIDTH-1:0] a,
  input  logic [DATA_WIDTH-1:0] b,
  input  logic [ROB_BITS-1:0]   rob,
  output logic                  ready,
  fu_result_if.unit             res
);

  import exec_pkg::*;

  logic                  valid_q;
  logic [ROB_BITS-1:0]   rob_q;
  logic [DATA_WIDTH-1:0] result_q;
  logic [DATA_WIDTH-1:0] result_d;
  logic                  accept;

  // free when empty or when the held result leaves this cycle
  assign ready = !valid_q || res.yumi;
  assign accept = issue_valid && ready;

  always_comb begin
    case (op)
      OP_ADD:  result_d = a + b;
      OP_SUB:  result_d = a - b;
      OP_AND:  result_d = a & b;
      OP_OR:   result_d = a | b;
      OP_XOR:  result_d = a ^ b;
      default: result_d = '0;
    endcase
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      valid_q <= 1'b0;
    end else if (accept) begin
      valid_q <= 1'b1;
    end else if (res.yumi) begin
      valid_q <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (accept) begin
      rob_q <= rob;
      result_q <= result_d;
    end
  end

  assign res.valid = valid_q;
  assign res.rob_entry = rob_q;
  assign res.result = result_q;

endmodule

`default_nettype wire

//--- hw/shift_control.sv
/*
 * Shift unit sequencer.
 * Walks idle -> shift -> done and holds the result until it is taken.
 */

`timescale 1ns/100ps
`default_nettype none

module shift_control (
  input  logic clk,
  input  logic reset,
  input  logic issue_valid,
  input  logic count_last,
  input  logic yumi,
  output logic load,
  output logic shifting,
  output logic done,
  output logic ready
);

  typedef enum logic [1:0] {
    s_idle  = 2'b00,
    s_shift = 2'b10,
    s_done  = 2'b11
  } state_t;

  state_t state;
  state_t next_state;

  assign ready = (state == s_idle);
  // issue is only taken while idle
  assign load = ready & issue_valid;
  assign shifting = (state == s_shift);
  assign done = (state == s_done);

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= s_idle;
    end else begin
      state <= next_state;
    end
  end

  always_comb begin
    next_state = state;
    case (state)
      s_idle:  if (issue_valid) next_state = s_shift;
      s_shift: if (count_last) next_state = s_done;
      s_done:  if (yumi) next_state = s_idle;
      default: next_state = s_idle;
    endcase
  end

endmodule

`default_nettype wire

//--- hw/shift_count.sv
/*
 * Shift position counter.
 * Loads the shift amount and counts down once per shifting cycle.
 */

`timescale 1ns/100ps
`default_nettype none

module shift_count #(
  parameter int DATA_WIDTH = exec_pkg::DEFAULT_DATA_WIDTH,
  localparam int AMT_BITS = $clog2(DATA_WIDTH)
) (
  input  logic                clk,
  input  logic                load,
  input  logic                shifting,
  input  logic [AMT_BITS-1:0] amount,
  output logic                step,
  output logic                count_last
);

  logic [AMT_BITS-1:0] count;

  // a zero count still spends one cycle in shift, but never steps
  assign step = shifting && (count != '0);
  assign count_last = (count <= AMT_BITS'(1));

  always_ff @(posedge clk) begin
    if (load) begin
      count <= amount;
    end else if (step) begin
      count <= count - AMT_BITS'(1);
    end
  end

endmodule

`default_nettype wire

//--- hw/shift_datapath.sv
/*
 * Shift unit datapath.
 * Holds the operand, tag and operation and moves the operand one bit per step.
 */

`timescale 1ns/100ps
`default_nettype none

module shift_datapath #(
  parameter int DATA_WIDTH = exec_pkg::DEFAULT_DATA_WIDTH,
  parameter int ROB_BITS = exec_pkg::DEFAULT_ROB_BITS,
  localparam int AMT_BITS = $clog2(DATA_WIDTH)
) (
  input  logic                  clk,
  input  logic                  reset,
  input  logic                  load,
  input  logic                  step,
  input  logic                  done,
  input  exec_pkg::alu_op_t     op,
  input  logic [DATA_WIDTH-1:0] a,
  input  logic [DATA_WIDTH-1:0] b,
  input  logic [ROB_BITS-1:0]   rob,
  output logic [AMT_BITS-1:0]   amount,
  fu_result_if.unit             res
);

  import exec_pkg::*;

  alu_op_t               op_q;
  logic [ROB_BITS-1:0]   rob_q;
  logic [DATA_WIDTH-1:0] value_q;

  // only the low bits of b count as shift amount
  assign amount = b[AMT_BITS-1:0];

  always_ff @(posedge clk) begin
    if (reset) begin
      op_q <= OP_SLL;
      rob_q <= '0;
    end else if (load) begin
      op_q <= op;
      rob_q <= rob;
    end
  end

  always_ff @(posedge clk) begin
    if (load) begin
      value_q <= a;
    end else if (step) begin
      case (op_q)
        OP_SLL:  value_q <= {value_q[DATA_WIDTH-2:0], 1'b0};
        OP_SRA:  value_q <= {value_q[DATA_WIDTH-1], value_q[DATA_WIDTH-1:1]};
        default: value_q <= {1'b0, value_q[DATA_WIDTH-1:1]};
      endcase
    end
  end

  assign res.valid = done;
  assign res.rob_entry = rob_q;
  assign res.result = value_q;

endmodule

`default_nettype wire

//--- run_sim.sh
#!/bin/sh
# build and run the execute cluster testbench, fail on the fail message in the log
rm -f sim.log
verilator --binary --timing --assert -Wno-fatal -f flist.f --top-module exec_cluster_tb \
  -o exec_cluster_sim &&
  ./obj_dir/exec_cluster_sim +verilator+error+limit+1000 > sim.log 2>&1 ||
  echo "simulation did not complete" >> sim.log
cat sim.log
grep -q "Testbench failed" sim.log && exit 1
grep -q "Testbench passed" sim.log || exit 1
exit 0

//--- sim/exec_cluster_assertions.sv
/*
 * Execute cluster protocol checks.
 * Shift latency, tag uniqueness, arbitration and ready strobes.
 */

`timescale 1ns/100ps
`default_nettype none

module exec_cluster_assertions #(
  parameter int DATA_WIDTH = exec_pkg::DEFAULT_DATA_WIDTH,
  parameter int ROB_BITS = exec_pkg::DEFAULT_ROB_BITS,
  localparam int AMT_BITS = $clog2(DATA_WIDTH)
) (
  input logic                  clk,
  input logic                  reset,
  input logic                  shift_valid,
  input logic                  shift_ready,
  input logic [DATA_WIDTH-1:0] shift_b,
  input logic [ROB_BITS-1:0]   shift_rob,
  input logic                  alu_valid,
  input logic                  alu_ready,
  input logic [ROB_BITS-1:0]   alu_rob,
  input logic                  shift_done,
  input logic                  shift_yumi,
  input logic                  logic_valid,
  input logic                  cdb_valid,
  input logic [ROB_BITS-1:0]   cdb_rob_entry
);

  int                    failures = 0;
  int                    wait_cycles;
  int                    expect_cycles;
  logic [ROB_BITS-1:0]   shift_tag;
  logic [2**ROB_BITS-1:0] in_flight;

  // max(k,1) cycles in shift, then valid on the next one
  function automatic int shift_latency(input logic [AMT_BITS-1:0] amount);
    return (amount == '0) ? 2 : int'(amount) + 1;
  endfunction

  always_ff @(posedge clk) begin
    if (reset) begin
      wait_cycles <= 0;
      expect_cycles <= 0;
      shift_tag <= '0;
    end else if (shift_valid && shift_ready) begin
      wait_cycles <= 1;
      expect_cycles <= shift_latency(shift_b[AMT_BITS-1:0]);
      shift_tag <= shift_rob;
    end else begin
      wait_cycles <= wait_cycles + 1;
    end
  end

  // tags issued but not yet seen on the bus
  always_ff @(posedge clk) begin
    if (reset) begin
      in_flight <= '0;
    end else begin
      if (cdb_valid) in_flight[cdb_rob_entry] <= 1'b0;
      if (shift_valid && shift_ready) in_flight[shift_rob] <= 1'b1;
      if (alu_valid && alu_ready) in_flight[alu_rob] <= 1'b1;
    end
  end

  a_reset_state: assert property (@(posedge clk)
    $fell(reset) |-> !cdb_valid && shift_ready && alu_ready)
    else begin
      failures = failures + 1;
      $error("bus or ready wrong after reset");
    end

  a_shift_latency: assert property (@(posedge clk) disable iff (reset)
    $rose(shift_done) |-> wait_cycles == expect_cycles)
    else begin
      failures = failures + 1;
      $error("shift result after %0d cycles", wait_cycles);
    end

  a_shift_on_bus: assert property (@(posedge clk) disable iff (reset)
    $rose(shift_done) && !logic_valid |-> cdb_valid && cdb_rob_entry == shift_tag)
    else begin
      failures = failures + 1;
      $error("shift result missing from idle bus");
    end

  a_loser_next: assert property (@(posedge clk) disable iff (reset)
    shift_done && logic_valid |=> cdb_valid)
    else begin
      failures = failures + 1;
      $error("held result not granted next cycle");
    end

  a_tag_once: assert property (@(posedge clk) disable iff (reset)
    cdb_valid |-> in_flight[cdb_rob_entry])
    else begin
      failures = failures + 1;
      $error("tag %0d not in flight", cdb_rob_entry);
    end

  a_shift_busy: assert property (@(posedge clk) disable iff (reset)
    (shift_valid && shift_ready) || (!shift_ready && !shift_yumi) |=> !shift_ready)
    else begin
      failures = failures + 1;
      $error("shift ready rose before its take");
    end

  a_shift_free: assert property (@(posedge clk) disable iff (reset)
    shift_yumi |=> shift_ready)
    else begin
      failures = failures + 1;
      $error("shift ready low after its take");
    end

  // with no shift result waiting, a held logic result leaves at once
  a_logic_back_to_back: assert property (@(posedge clk) disable iff (reset)
    !shift_done |-> alu_ready)
    else begin
      failures = failures + 1;
      $error("logic unit not ready while the bus is free");
    end

endmodule

`default_nettype wire

//--- sim/exec_cluster_tb.sv
/*
 * Execute cluster testbench.
 * Issues logic and shift operations and checks every bus result by its tag.
 */

`timescale 1ns/100ps
`default_nettype none

module exec_cluster_tb;

  import exec_pkg::*;

  localparam int DATA_WIDTH = 32;
  localparam int ROB_BITS = 4;
  localparam int MAX_CYCLES = 3000;

  logic                  clk = 1'b0;
  logic                  reset = 1'b1;
  logic                  shift_valid = 1'b0;
  alu_op_t               shift_op = OP_SLL;
  logic [DATA_WIDTH-1:0] shift_a = '0;
  logic [DATA_WIDTH-1:0] shift_b = '0;
  logic [ROB_BITS-1:0]   shift_rob = '0;
  logic                  shift_ready;
  logic                  alu_valid = 1'b0;
  alu_op_t               alu_op = OP_ADD;
  logic [DATA_WIDTH-1:0] alu_a = '0;
  logic [DATA_WIDTH-1:0] alu_b = '0;
  logic [ROB_BITS-1:0]   alu_rob = '0;
  logic                  alu_ready;
  logic                  cdb_valid;
  logic [ROB_BITS-1:0]   cdb_rob_entry;
  logic [DATA_WIDTH-1:0] cdb_result;

  logic [DATA_WIDTH-1:0] expected [int];
  bit                    from_logic [int];
  logic [ROB_BITS-1:0]   logic_order [$];
  logic [ROB_BITS-1:0]   next_tag = '0;
  int                    errors = 0;
  int                    cycles = 0;
  int                    seed;

  exec_cluster #(.DATA_WIDTH(DATA_WIDTH), .ROB_BITS(ROB_BITS)) i_dut (.*);

  bind exec_cluster exec_cluster_assertions #(.DATA_WIDTH(DATA_WIDTH), .ROB_BITS(ROB_BITS))
    i_assertions (
      .clk(clk), .reset(reset), .shift_valid(shift_valid), .shift_ready(shift_ready),
      .shift_b(shift_b), .shift_rob(shift_rob), .alu_valid(alu_valid),
      .alu_ready(alu_ready), .alu_rob(alu_rob), .shift_done(shift_done),
      .shift_yumi(shift_if.yumi), .logic_valid(logic_if.valid),
      .cdb_valid(cdb_valid), .cdb_rob_entry(cdb_rob_entry)
    );

  always #2 clk = ~clk;

  function automatic logic [DATA_WIDTH-1:0] reference_result(input alu_op_t op,
      input logic [DATA_WIDTH-1:0] a, input logic [DATA_WIDTH-1:0] b);
    int k;
    k = int'(b & (DATA_WIDTH - 1));
    case (op)
      OP_ADD:  return a + b;
      OP_SUB:  return a - b;
      OP_AND:  return a & b;
      OP_OR:   return a | b;
      OP_XOR:  return a ^ b;
      OP_SLL:  return a << k;
      OP_SRL:  return a >> k;
      OP_SRA:  return $unsigned($signed(a) >>> k);
      default: return '0;
    endcase
  endfunction

  task automatic issue_op(input bit to_shift, input alu_op_t op,
      input logic [DATA_WIDTH-1:0] a, input logic [DATA_WIDTH-1:0] b);
    logic [ROB_BITS-1:0] tag;
    tag = next_tag;
    next_tag = next_tag + 1'b1;
    while (to_shift ? !shift_ready : !alu_ready) begin
      @(posedge clk);
      #1;
    end
    expected[int'(tag)] = reference_result(op, a, b);
    if (to_shift) begin
      shift_valid = 1'b1;
      shift_op = op;
      shift_a = a;
      shift_b = b;
      shift_rob = tag;
    end else begin
      alu_valid = 1'b1;
      alu_op = op;
      alu_a = a;
      alu_b = b;
      alu_rob = tag;
      from_logic[int'(tag)] = 1'b1;
      logic_order.push_back(tag);
    end
    @(posedge clk);
    #1;
    shift_valid = 1'b0;
    alu_valid = 1'b0;
  endtask

  task automatic wait_drained();
    @(posedge clk);
    #1;
    while (expected.num() != 0) begin
      @(posedge clk);
      #1;
    end
  endtask

  // bus results compared against the reference values by tag
  always @(posedge clk) begin
    int tag;
    if (!reset && cdb_valid) begin
      tag = int'(cdb_rob_entry);
      if (!expected.exists(tag)) begin
        errors++;
        $display("Error at %0t: bus result with unknown tag %0d", $time, tag);
      end else begin
        if (cdb_result !== expected[tag]) begin
          errors++;
          $display("Error at %0t: tag %0d gave %h, expected %h", $time, tag, cdb_result,
                   expected[tag]);
        end
        if (from_logic.exists(tag)) begin
          if (logic_order[0] != cdb_rob_entry) begin
            errors++;
            $display("Error at %0t: logic tag %0d out of issue order", $time, tag);
          end
          void'(logic_order.pop_front());
          from_logic.delete(tag);
        end
        expected.delete(tag);
      end
    end
  end

  always @(posedge clk) begin
    cycles++;
    if (cycles >= MAX_CYCLES) begin
      $display("Timeout: run not finished after %0d cycles, %0d errors so far", cycles, errors);
      $display("Testbench failed");
      $finish;
    end
  end

  initial begin
    int amt;
    logic [DATA_WIDTH-1:0] a;
    logic [DATA_WIDTH-1:0] b;
    seed = 2119;
    repeat (8) @(posedge clk);
    #1;
    reset = 1'b0;

    // each logic operation on random operands
    for (int i = 0; i < 15; i++) begin
      issue_op(1'b0, alu_op_t'(i % 5), $random(seed), $random(seed));
      wait_drained();
    end

    // shifts with amounts 0, 1, width-1 and two random ones
    for (int op = 5; op <= 7; op++) begin
      for (int j = 0; j < 5; j++) begin
        case (j)
          0:       amt = 0;
          1:       amt = 1;
          2:       amt = DATA_WIDTH - 1;
          default: amt = $random(seed) & (DATA_WIDTH - 1);
        endcase
        a = $random(seed);
        if (alu_op_t'(op) == OP_SRA) a[DATA_WIDTH-1] = 1'b1;
        b = ($random(seed) & ~(DATA_WIDTH - 1)) | amt;
        issue_op(1'b1, alu_op_t'(op), a, b);
        wait_drained();
      end
    end

    // both units finish together, each wins once
    for (int i = 0; i < 2; i++) begin
      issue_op(1'b1, OP_SRL, $random(seed), '0);
      issue_op(1'b0, OP_XOR, $random(seed), $random(seed));
      wait_drained();
    end

    // back-to-back logic issues, with a shift ending in the middle
    issue_op(1'b1, OP_SLL, $random(seed), 32'd3);
    for (int i = 0; i < 8; i++) begin
      issue_op(1'b0, alu_op_t'(i % 5), $random(seed), $random(seed));
    end
    wait_drained();
    repeat (2) @(posedge clk);

    $display("Checks done: %0d value errors, %0d assertion failures", errors,
             i_dut.i_assertions.failures);
    if (errors == 0 && i_dut.i_assertions.failures == 0) begin
      $display("Testbench passed");
    end else begin
      $display("Testbench failed");
    end
    $finish;
  end

endmodule

`default_nettype wire
